//--- Bender.yml
package:
  name: rv32im_exec

sources:
  # design, package first
  - rtl/rv32im_pkg.sv
  - rtl/rv32im_alu.sv
  - rtl/rv32im_muldiv.sv
  - rtl/rv32im_wb_merge.sv
  - rtl/rv32im_exec_unit.sv
  # testbench, top module rv32im_exec_tb
  - target: simulation
    files:
      - verif/rv32im_clk_gen.sv
      - verif/rv32im_exec_checker.sv
      - verif/rv32im_exec_tb.sv

//--- flist.f
rtl/rv32im_pkg.sv
rtl/rv32im_alu.sv
rtl/rv32im_muldiv.sv
rtl/rv32im_wb_merge.sv
rtl/rv32im_exec_unit.sv
verif/rv32im_clk_gen.sv
verif/rv32im_exec_checker.sv
verif/rv32im_exec_tb.sv

//--- rtl/rv32im_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_alu (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire                          clear_i,
  input  wire                          alu_issue_i,
  input  wire rv32im_pkg::exec_op_e    op_i,
  input  wire [rv32im_pkg::xlen-1:0]   operand1_i,
  input  wire [rv32im_pkg::xlen-1:0]   operand2_i,
  input  wire [rv32im_pkg::tag_w-1:0]  tag_i,
  output logic                         alu_valid_o,
  output logic [rv32im_pkg::xlen-1:0]  alu_result_o,
  output logic [rv32im_pkg::tag_w-1:0] alu_tag_o,
  output logic                         equal_o,
  output logic                         less_o,
  output logic                         less_signed_o
);

  // mirror a word end to end so the right shifter can also shift left
  function automatic logic [rv32im_pkg::xlen-1:0] bit_rev(
    input logic [rv32im_pkg::xlen-1:0] v
  );
    logic [rv32im_pkg::xlen-1:0] r;
    for (int i = 0; i < rv32im_pkg::xlen; i++) begin
      r[i] = v[rv32im_pkg::xlen-1-i];
    end
    return r;
  endfunction

  logic [rv32im_pkg::xlen:0]          diff;
  logic                               less;
  logic                               less_signed;
  logic                               equal;
  logic                               is_sll;
  logic                               is_sra;
  logic [rv32im_pkg::xlen-1:0]        shift_in;
  logic signed [rv32im_pkg::xlen:0]   shift_ext;
  logic signed [rv32im_pkg::xlen:0]   shift_full;
  logic [rv32im_pkg::xlen-1:0]        shift_right;
  logic [rv32im_pkg::xlen-1:0]        shift_left;
  logic [rv32im_pkg::xlen-1:0]        result_d;

  // one 33-bit subtract, the top bit is the unsigned borrow
  assign diff = {1'b0, operand1_i} - {1'b0, operand2_i};
  assign less = diff[rv32im_pkg::xlen];
  assign equal = (diff[rv32im_pkg::xlen-1:0] == '0);
  // differing signs decide directly, otherwise the borrow does
  assign less_signed = (operand1_i[rv32im_pkg::xlen-1] ^ operand2_i[rv32im_pkg::xlen-1]) ?
                       operand1_i[rv32im_pkg::xlen-1] : less;

  assign is_sll = (op_i == rv32im_pkg::op_sll);
  assign is_sra = (op_i == rv32im_pkg::op_sra);

  // reversed input for sll, fill bit is the sign only for sra
  assign shift_in = is_sll ? bit_rev(operand1_i) : operand1_i;
  assign shift_ext = {is_sra & operand1_i[rv32im_pkg::xlen-1], shift_in};
  assign shift_full = shift_ext >>> operand2_i[$clog2(rv32im_pkg::xlen)-1:0];
  assign shift_right = shift_full[rv32im_pkg::xlen-1:0];
  // undo the reversal for sll
  assign shift_left = bit_rev(shift_right);

  always_comb begin
    case (op_i)
      rv32im_pkg::op_add:  result_d = operand1_i + operand2_i;
      rv32im_pkg::op_sub:  result_d = diff[rv32im_pkg::xlen-1:0];
      rv32im_pkg::op_slt:  result_d = {{(rv32im_pkg::xlen-1){1'b0}}, less_signed};
      rv32im_pkg::op_sltu: result_d = {{(rv32im_pkg::xlen-1){1'b0}}, less};
      rv32im_pkg::op_and:  result_d = operand1_i & operand2_i;
      rv32im_pkg::op_or:   result_d = operand1_i | operand2_i;
      rv32im_pkg::op_xor:  result_d = operand1_i ^ operand2_i;
      rv32im_pkg::op_sll:  result_d = shift_left;
      rv32im_pkg::op_srl:  result_d = shift_right;
      rv32im_pkg::op_sra:  result_d = shift_right;
      // m operations never reach this unit
      default:             result_d = '0;
    endcase
  end

  // valid strobe and branch flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_valid_o   <= 1'b0;
      equal_o       <= 1'b0;
      less_o        <= 1'b0;
      less_signed_o <= 1'b0;
    end else if (clear_i) begin
      alu_valid_o   <= 1'b0;
      equal_o       <= 1'b0;
      less_o        <= 1'b0;
      less_signed_o <= 1'b0;
    end else begin
      alu_valid_o <= alu_issue_i;
      // flags hold their value between alu issues
      if (alu_issue_i) begin
        equal_o       <= equal;
        less_o        <= less;
        less_signed_o <= less_signed;
      end
    end
  end

  // result and tag, zeroed by a flush
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      alu_result_o <= '0;
      alu_tag_o    <= '0;
    end else if (alu_issue_i) begin
      alu_result_o <= result_d;
      alu_tag_o    <= tag_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv32im_exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_exec_unit (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire                          clear_i,
  input  wire                          issue_i,
  input  wire rv32im_pkg::exec_op_e    op_i,
  input  wire [rv32im_pkg::xlen-1:0]   operand1_i,
  input  wire [rv32im_pkg::xlen-1:0]   operand2_i,
  input  wire [rv32im_pkg::tag_w-1:0]  tag_i,
  output logic                         result_valid_o,
  output logic [rv32im_pkg::xlen-1:0]  result_o,
  output logic [rv32im_pkg::tag_w-1:0] result_tag_o,
  output logic                         equal_o,
  output logic                         less_o,
  output logic                         less_signed_o,
  output logic                         busy_o
);

  logic                         alu_issue;
  logic                         md_issue;
  logic                         alu_valid;
  logic [rv32im_pkg::xlen-1:0]  alu_result;
  logic [rv32im_pkg::tag_w-1:0] alu_tag;
  logic                         md_valid;
  logic [rv32im_pkg::xlen-1:0]  md_result;
  logic [rv32im_pkg::tag_w-1:0] md_tag;
  logic                         md_hold;

  // bit 4 of the opcode picks the unit
  assign alu_issue = issue_i && !op_i[4];
  assign md_issue = issue_i && op_i[4];

  rv32im_alu u_alu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .clear_i       (clear_i),
    .alu_issue_i   (alu_issue),
    .op_i          (op_i),
    .operand1_i    (operand1_i),
    .operand2_i    (operand2_i),
    .tag_i         (tag_i),
    .alu_valid_o   (alu_valid),
    .alu_result_o  (alu_result),
    .alu_tag_o     (alu_tag),
    .equal_o       (equal_o),
    .less_o        (less_o),
    .less_signed_o (less_signed_o)
  );

  rv32im_muldiv u_muldiv (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .md_issue_i  (md_issue),
    .op_i        (op_i),
    .operand1_i  (operand1_i),
    .operand2_i  (operand2_i),
    .tag_i       (tag_i),
    .md_hold_i   (md_hold),
    .md_valid_o  (md_valid),
    .md_result_o (md_result),
    .md_tag_o    (md_tag),
    .busy_o      (busy_o)
  );

  // single tagged result stream
  rv32im_wb_merge u_wb_merge (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .clear_i        (clear_i),
    .alu_valid_i    (alu_valid),
    .alu_result_i   (alu_result),
    .alu_tag_i      (alu_tag),
    .md_valid_i     (md_valid),
    .md_result_i    (md_result),
    .md_tag_i       (md_tag),
    .md_hold_o      (md_hold),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_tag_o   (result_tag_o)
  );

endmodule

`default_nettype wire

//--- rtl/rv32im_muldiv.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_muldiv (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire                          clear_i,
  input  wire                          md_issue_i,
  input  wire rv32im_pkg::exec_op_e    op_i,
  input  wire [rv32im_pkg::xlen-1:0]   operand1_i,
  input  wire [rv32im_pkg::xlen-1:0]   operand2_i,
  input  wire [rv32im_pkg::tag_w-1:0]  tag_i,
  input  wire                          md_hold_i,
  output logic                         md_valid_o,
  output logic [rv32im_pkg::xlen-1:0]  md_result_o,
  output logic [rv32im_pkg::tag_w-1:0] md_tag_o,
  output logic                         busy_o
);

  localparam int w = rv32im_pkg::xlen;

  rv32im_pkg::md_state_e                state_q;
  logic [rv32im_pkg::div_cnt_w-1:0]     count_q;
  rv32im_pkg::exec_op_e                 op_q;
  logic [rv32im_pkg::tag_w-1:0]         tag_q;
  // operands with their extension bit, also keep the raw divide inputs
  logic signed [w:0]                    a_q;
  logic signed [w:0]                    b_q;
  logic signed [2*w+1:0]                product;
  // divider registers, quotient shifts in as the dividend shifts out
  logic [w-1:0]                         rem_q;
  logic [w-1:0]                         quo_q;
  logic [w-1:0]                         dsr_q;
  logic [w:0]                           shifted;
  logic [w:0]                           trial;
  logic                                 a_signed;
  logic                                 b_signed;
  logic                                 div_signed;
  logic                                 div_zero;
  logic                                 div_ovf;
  logic [w-1:0]                         quo_fix;
  logic [w-1:0]                         rem_fix;
  logic [w-1:0]                         result_q;

  // which operands count as signed at issue
  assign a_signed = (op_i == rv32im_pkg::op_mul) || (op_i == rv32im_pkg::op_mulh) ||
                    (op_i == rv32im_pkg::op_mulhsu) || (op_i == rv32im_pkg::op_div) ||
                    (op_i == rv32im_pkg::op_rem);
  assign b_signed = (op_i == rv32im_pkg::op_mul) || (op_i == rv32im_pkg::op_mulh) ||
                    (op_i == rv32im_pkg::op_div) || (op_i == rv32im_pkg::op_rem);

  // 33x33 signed multiply covers every sign combination
  assign product = a_q * b_q;

  // one restoring step
  assign shifted = {rem_q, quo_q[w-1]};
  assign trial = shifted - {1'b0, dsr_q};

  // sign handling and risc-v special cases
  assign div_signed = (op_q == rv32im_pkg::op_div) || (op_q == rv32im_pkg::op_rem);
  assign div_zero = (b_q[w-1:0] == '0);
  assign div_ovf = div_signed && (a_q[w-1:0] == {1'b1, {(w-1){1'b0}}}) &&
                   (b_q[w-1:0] == '1);

  always_comb begin
    if (div_zero) begin
      quo_fix = '1;
      rem_fix = a_q[w-1:0];
    end else if (div_ovf) begin
      quo_fix = {1'b1, {(w-1){1'b0}}};
      rem_fix = '0;
    end else begin
      // quotient negative when signs differ, remainder takes the dividend sign
      quo_fix = (div_signed && (a_q[w-1] ^ b_q[w-1])) ? -quo_q : quo_q;
      rem_fix = (div_signed && a_q[w-1]) ? -rem_q : rem_q;
    end
  end

  // sequencer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= rv32im_pkg::md_idle;
      count_q <= '0;
    end else if (clear_i) begin
      // flush aborts whatever is running
      state_q <= rv32im_pkg::md_idle;
      count_q <= '0;
    end else begin
      case (state_q)
        rv32im_pkg::md_idle: begin
          count_q <= '0;
          if (md_issue_i) begin
            state_q <= op_i[2] ? rv32im_pkg::md_div : rv32im_pkg::md_mul;
          end
        end
        rv32im_pkg::md_mul: state_q <= rv32im_pkg::md_done;
        rv32im_pkg::md_div: begin
          count_q <= count_q + 1'b1;
          if (count_q == rv32im_pkg::div_cnt_w'(rv32im_pkg::div_steps - 1)) begin
            state_q <= rv32im_pkg::md_fix;
          end
        end
        rv32im_pkg::md_fix: state_q <= rv32im_pkg::md_done;
        default:            state_q <= rv32im_pkg::md_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk_i) begin
    case (state_q)
      rv32im_pkg::md_idle: begin
        if (md_issue_i) begin
          op_q  <= op_i;
          tag_q <= tag_i;
          a_q   <= {a_signed & operand1_i[w-1], operand1_i};
          b_q   <= {b_signed & operand2_i[w-1], operand2_i};
          rem_q <= '0;
          // divider works on magnitudes
          quo_q <= (a_signed && operand1_i[w-1]) ? -operand1_i : operand1_i;
          dsr_q <= (b_signed && operand2_i[w-1]) ? -operand2_i : operand2_i;
        end
      end
      rv32im_pkg::md_mul: begin
        result_q <= (op_q == rv32im_pkg::op_mul) ? product[w-1:0] : product[2*w-1:w];
      end
      rv32im_pkg::md_div: begin
        // keep the difference only when it did not borrow
        rem_q <= trial[w] ? shifted[w-1:0] : trial[w-1:0];
        quo_q <= {quo_q[w-2:0], ~trial[w]};
      end
      rv32im_pkg::md_fix: begin
        result_q <= ((op_q == rv32im_pkg::op_div) || (op_q == rv32im_pkg::op_divu)) ?
                    quo_fix : rem_fix;
      end
      default: ;
    endcase
  end

  assign md_valid_o = (state_q == rv32im_pkg::md_done);
  assign md_result_o = result_q;
  assign md_tag_o = tag_q;
  // still busy while the merger keeps our result waiting
  assign busy_o = (state_q != rv32im_pkg::md_idle) || md_hold_i;

endmodule

`default_nettype wire

//--- rtl/rv32im_pkg.sv
`default_nettype none

package rv32im_pkg;

  // datapath width, the shifter is built for exactly 32 bits
  localparam int xlen = 32;

  // destination register number carried with every result
  localparam int tag_w = 5;

  // restoring divider produces one quotient bit per step
  localparam int div_steps = 32;
  // width of the divide step counter
  localparam int div_cnt_w = $clog2(div_steps);

  // execute operations
  // bit 4 clear routes to the alu, low nibble follows the funct7/funct3 style codes
  // bit 4 set routes to the multiply/divide unit
  typedef enum logic [4:0] {
    op_add    = 5'b00000,
    op_sll    = 5'b00001,
    op_slt    = 5'b00010,
    op_sltu   = 5'b00011,
    op_xor    = 5'b00100,
    op_srl    = 5'b00101,
    op_or     = 5'b00110,
    op_and    = 5'b00111,
    op_sub    = 5'b01000,
    op_sra    = 5'b01101,
    // m extension, bit 2 set marks the divide group
    op_mul    = 5'b10000,
    op_mulh   = 5'b10001,
    op_mulhsu = 5'b10010,
    op_mulhu  = 5'b10011,
    op_div    = 5'b10100,
    op_divu   = 5'b10101,
    op_rem    = 5'b10110,
    op_remu   = 5'b10111
  } exec_op_e;

  // multiply/divide sequencer
  typedef enum logic [2:0] {
    md_idle,
    md_mul,
    md_div,
    md_fix,
    md_done
  } md_state_e;

endpackage

`default_nettype wire

//--- rtl/rv32im_wb_merge.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_wb_merge (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire                          clear_i,
  input  wire                          alu_valid_i,
  input  wire [rv32im_pkg::xlen-1:0]   alu_result_i,
  input  wire [rv32im_pkg::tag_w-1:0]  alu_tag_i,
  input  wire                          md_valid_i,
  input  wire [rv32im_pkg::xlen-1:0]   md_result_i,
  input  wire [rv32im_pkg::tag_w-1:0]  md_tag_i,
  output logic                         md_hold_o,
  output logic                         result_valid_o,
  output logic [rv32im_pkg::xlen-1:0]  result_o,
  output logic [rv32im_pkg::tag_w-1:0] result_tag_o
);

  // one-entry hold for a muldiv result that lost to the alu
  logic                         hold_valid_q;
  logic [rv32im_pkg::xlen-1:0]  hold_result_q;
  logic [rv32im_pkg::tag_w-1:0] hold_tag_q;
  logic                         collide;

  // fresh muldiv result meets an alu result
  assign collide = alu_valid_i && md_valid_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (collide) begin
      hold_valid_q <= 1'b1;
    end else if (!alu_valid_i) begin
      // held entry leaves on the first free cycle
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (collide) begin
      hold_result_q <= md_result_i;
      hold_tag_q    <= md_tag_i;
    end
  end

  assign md_hold_o = hold_valid_q;

  // alu first, then the held entry, then a fresh muldiv result
  always_comb begin
    if (alu_valid_i) begin
      result_o     = alu_result_i;
      result_tag_o = alu_tag_i;
    end else if (hold_valid_q) begin
      result_o     = hold_result_q;
      result_tag_o = hold_tag_q;
    end else begin
      result_o     = md_result_i;
      result_tag_o = md_tag_i;
    end
  end

  // a flush suppresses whatever is on its way out this cycle
  assign result_valid_o = !clear_i && (alu_valid_i || hold_valid_q || md_valid_i);

endmodule

`default_nettype wire

//--- verif/rv32im_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset low for the first 10 rising edges, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/rv32im_exec_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_exec_checker (
  input wire       clk_i,
  input wire       rst_n_i,
  input wire       clear_i,
  input wire       issue_i,
  input wire [4:0] op_i,
  input wire       busy_i,
  input wire       result_valid_i
);

  // number of failed assertions
  int fail_cnt = 0;

  // a multiply/divide may only start while the unit is free
  md_issue_when_free: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(issue_i && op_i[4] && busy_i)
  ) else begin
    fail_cnt++;
    $error("multiply/divide issued while busy_o is high");
  end

  // output strobe is always known once out of reset
  result_valid_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(result_valid_i)
  ) else begin
    fail_cnt++;
    $error("result_valid_o is unknown");
  end

  // alu result always wins the merger one cycle later, a flush cancels it
  alu_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      (issue_i && !op_i[4] && !clear_i) |=> (result_valid_i || clear_i)
  ) else begin
    fail_cnt++;
    $error("alu issue not followed by result_valid_o one cycle later");
  end

endmodule

bind rv32im_exec_unit rv32im_exec_checker u_checker (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .clear_i        (clear_i),
  .issue_i        (issue_i),
  .op_i           (op_i),
  .busy_i         (busy_o),
  .result_valid_i (result_valid_o)
);

`default_nettype wire

//--- verif/rv32im_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv32im_exec_tb;

  logic                         clk;
  logic                         rst_n;
  logic                         clear;
  logic                         issue;
  rv32im_pkg::exec_op_e         op;
  logic [rv32im_pkg::xlen-1:0]  operand1;
  logic [rv32im_pkg::xlen-1:0]  operand2;
  logic [rv32im_pkg::tag_w-1:0] tag;
  logic                         result_valid;
  logic [rv32im_pkg::xlen-1:0]  result;
  logic [rv32im_pkg::tag_w-1:0] result_tag;
  logic                         equal;
  logic                         less;
  logic                         less_signed;
  logic                         busy;

  // scoreboard, one entry per destination tag
  logic                         pending [32];
  logic                         is_alu [32];
  logic [rv32im_pkg::xlen-1:0]  exp_val [32];
  // equal, less, less signed
  logic [2:0]                   exp_flags [32];
  rv32im_pkg::exec_op_e         exp_op [32];
  int                           issue_cyc [32];
  int                           pending_cnt;
  int                           next_tag;
  int                           cycle_cnt = 0;
  int                           err_cnt;
  int                           chk_cnt;
  logic [rv32im_pkg::tag_w-1:0] rtag;

  // edge operand pairs: sign bits, shift amounts 0, 31 and one with bits above the mask
  logic [rv32im_pkg::xlen-1:0] alu_a [7] = '{32'h0, 32'h8000_0000, 32'h8000_0000,
    32'hffff_ffff, 32'h7fff_ffff, 32'h1234_5678, 32'h8000_0001};
  logic [rv32im_pkg::xlen-1:0] alu_b [7] = '{32'h0, 32'd31, 32'd0,
    32'h8000_0000, 32'h8000_0000, 32'h1234_5678, 32'h0000_003f};
  // divide by zero, signed overflow, mixed signs
  logic [rv32im_pkg::xlen-1:0] md_a [7] = '{32'd7, 32'h8000_0000, 32'hffff_fff9,
    32'd7, 32'hffff_ffff, 32'h8000_0000, 32'd100};
  logic [rv32im_pkg::xlen-1:0] md_b [7] = '{32'd0, 32'hffff_ffff, 32'd2,
    32'hffff_fffe, 32'hffff_ffff, 32'd0, 32'd7};

  rv32im_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv32im_exec_unit UUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .clear_i        (clear),
    .issue_i        (issue),
    .op_i           (op),
    .operand1_i     (operand1),
    .operand2_i     (operand2),
    .tag_i          (tag),
    .result_valid_o (result_valid),
    .result_o       (result),
    .result_tag_o   (result_tag),
    .equal_o        (equal),
    .less_o         (less),
    .less_signed_o  (less_signed),
    .busy_o         (busy)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // expected result straight from the rv32i and m extension rules
  function automatic logic [rv32im_pkg::xlen-1:0] exec_ref(
    input rv32im_pkg::exec_op_e o,
    input logic [rv32im_pkg::xlen-1:0] a,
    input logic [rv32im_pkg::xlen-1:0] b
  );
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] prod;
    logic        div0;
    logic        ovf;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    div0 = (b == 32'd0);
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (o)
      rv32im_pkg::op_add:  return a + b;
      rv32im_pkg::op_sub:  return a - b;
      rv32im_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv32im_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
      rv32im_pkg::op_and:  return a & b;
      rv32im_pkg::op_or:   return a | b;
      rv32im_pkg::op_xor:  return a ^ b;
      rv32im_pkg::op_sll:  return a << b[4:0];
      rv32im_pkg::op_srl:  return a >> b[4:0];
      rv32im_pkg::op_sra:  return $signed(a) >>> b[4:0];
      rv32im_pkg::op_mul: begin
        prod = {32'd0, a} * {32'd0, b};
        return prod[31:0];
      end
      rv32im_pkg::op_mulh: begin
        prod = sa * sb;
        return prod[63:32];
      end
      rv32im_pkg::op_mulhsu: begin
        prod = sa * {32'd0, b};
        return prod[63:32];
      end
      rv32im_pkg::op_mulhu: begin
        prod = {32'd0, a} * {32'd0, b};
        return prod[63:32];
      end
      rv32im_pkg::op_div: begin
        if (div0) return 32'hffff_ffff;
        else if (ovf) return 32'h8000_0000;
        else return $signed(a) / $signed(b);
      end
      rv32im_pkg::op_divu: return div0 ? 32'hffff_ffff : a / b;
      rv32im_pkg::op_rem: begin
        if (div0) return a;
        else if (ovf) return 32'd0;
        else return $signed(a) % $signed(b);
      end
      default: return div0 ? a : a % b;
    endcase
  endfunction

  function automatic rv32im_pkg::exec_op_e pick_alu_op(input int unsigned i);
    case (i % 10)
      0: return rv32im_pkg::op_add;
      1: return rv32im_pkg::op_sub;
      2: return rv32im_pkg::op_slt;
      3: return rv32im_pkg::op_sltu;
      4: return rv32im_pkg::op_and;
      5: return rv32im_pkg::op_or;
      6: return rv32im_pkg::op_xor;
      7: return rv32im_pkg::op_sll;
      8: return rv32im_pkg::op_srl;
      default: return rv32im_pkg::op_sra;
    endcase
  endfunction

  // m operations sit in order from 10000
  function automatic rv32im_pkg::exec_op_e pick_md_op(input int unsigned i);
    return rv32im_pkg::exec_op_e'(5'b10000 | 5'(i % 8));
  endfunction

  // random word, biased towards edge values and small shift amounts
  function automatic logic [rv32im_pkg::xlen-1:0] rand_operand();
    case ($urandom_range(0, 7))
      0: return 32'h0;
      1: return 32'h8000_0000;
      2: return 32'hffff_ffff;
      3: return 32'h7fff_ffff;
      4: return 32'($urandom_range(0, 31));
      default: return $urandom();
    endcase
  endfunction

  // next tag not in flight, -1 if all are taken
  function automatic int free_tag();
    int t;
    for (int i = 0; i < 32; i++) begin
      t = (next_tag + i) % 32;
      if (!pending[t]) return t;
    end
    return -1;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // issue left high so back to back calls give one issue per cycle
  task automatic drive_op(
    input rv32im_pkg::exec_op_e o,
    input logic [rv32im_pkg::xlen-1:0] a,
    input logic [rv32im_pkg::xlen-1:0] b
  );
    int n;
    int t;
    @(posedge clk);
    #1;
    n = 0;
    // multiply/divide waits for a free unit
    while (o[4] && busy && n < 100) begin
      issue = 1'b0;
      @(posedge clk);
      #1;
      n++;
    end
    t = free_tag();
    if (o[4] && busy) begin
      err_cnt++;
      issue = 1'b0;
      $display("busy_o stayed high for 100 cycles, %s was not issued", o.name());
    end else if (t < 0) begin
      err_cnt++;
      issue = 1'b0;
      $display("no free tag left, %s was not issued", o.name());
    end else begin
      next_tag = (t + 1) % 32;
      pending[t] = 1'b1;
      pending_cnt++;
      is_alu[t] = !o[4];
      exp_val[t] = exec_ref(o, a, b);
      exp_flags[t] = {a == b, a < b, $signed(a) < $signed(b)};
      exp_op[t] = o;
      issue_cyc[t] = cycle_cnt;
      issue = 1'b1;
      op = o;
      operand1 = a;
      operand2 = b;
      tag = t[rv32im_pkg::tag_w-1:0];
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    issue = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) idle_cycle();
  endtask

  // wait for every outstanding tag, then the unit must be free
  task automatic drain_results();
    int n;
    idle_cycle();
    n = 0;
    while (pending_cnt > 0 && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pending_cnt > 0) begin
      for (int i = 0; i < 32; i++) begin
        if (pending[i]) begin
          err_cnt++;
          $display("missing result: tag %0d (%s) not returned within 100 cycles",
                   i, exp_op[i].name());
          pending[i] = 1'b0;
        end
      end
      pending_cnt = 0;
    end else begin
      check_bit("busy_o", busy, 1'b0);
    end
  endtask

  // one cycle of clear, nothing in flight survives it
  task automatic flush_stage();
    @(posedge clk);
    #1;
    issue = 1'b0;
    clear = 1'b1;
    for (int i = 0; i < 32; i++) begin
      pending[i] = 1'b0;
    end
    pending_cnt = 0;
    @(posedge clk);
    #1;
    clear = 1'b0;
    check_bit("equal_o", equal, 1'b0);
    check_bit("less_o", less, 1'b0);
    check_bit("less_signed_o", less_signed, 1'b0);
    check_bit("busy_o", busy, 1'b0);
  endtask

  // compare every result mid cycle, where outputs are settled
  always @(negedge clk) begin
    if (rst_n && result_valid === 1'b1) begin
      rtag = result_tag;
      if (pending[rtag] !== 1'b1) begin
        err_cnt++;
        $display("unexpected result at %0t: tag %0d has no operation in flight", $time, rtag);
      end else begin
        chk_cnt++;
        if (result !== exp_val[rtag]) begin
          err_cnt++;
          $display("error at %0t: result_o = %h, expected %h (tag %0d, %s)",
                   $time, result, exp_val[rtag], rtag, exp_op[rtag].name());
        end
        if (is_alu[rtag]) begin
          // alu result exactly one cycle after issue
          if (cycle_cnt != issue_cyc[rtag] + 1) begin
            err_cnt++;
            $display("error at %0t: result_valid_o for tag %0d in cycle %0d, expected %0d",
                     $time, rtag, cycle_cnt, issue_cyc[rtag] + 1);
          end
          check_bit("equal_o", equal, exp_flags[rtag][2]);
          check_bit("less_o", less, exp_flags[rtag][1]);
          check_bit("less_signed_o", less_signed, exp_flags[rtag][0]);
        end
        pending[rtag] = 1'b0;
        pending_cnt--;
      end
    end
  end

  initial begin
    int n;
    void'($urandom(32'h2ea8));
    clear = 1'b0;
    issue = 1'b0;
    op = rv32im_pkg::op_add;
    operand1 = '0;
    operand2 = '0;
    tag = '0;
    for (int i = 0; i < 32; i++) begin
      pending[i] = 1'b0;
    end
    pending_cnt = 0;
    next_tag = 0;
    err_cnt = 0;
    chk_cnt = 0;

    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      err_cnt++;
      $display("reset was never released");
    end
    check_bit("result_valid_o", result_valid, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("equal_o", equal, 1'b0);
    check_bit("less_o", less, 1'b0);
    check_bit("less_signed_o", less_signed, 1'b0);

    // every alu operation over the edge pairs, back to back
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 7; j++) begin
        drive_op(pick_alu_op(i), alu_a[j], alu_b[j]);
      end
    end
    drain_results();
    repeat (300) drive_op(pick_alu_op($urandom_range(0, 9)), rand_operand(), rand_operand());
    drain_results();

    // every m operation over the special pairs, then random ones
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 7; j++) begin
        drive_op(pick_md_op(i), md_a[j], md_b[j]);
        drain_results();
      end
    end
    repeat (40) begin
      drive_op(pick_md_op($urandom_range(0, 7)), rand_operand(), rand_operand());
      drain_results();
    end

    // alu traffic across the muldiv finish, solid in even rounds, gapped in odd ones
    for (int r = 0; r < 12; r++) begin
      drive_op(pick_md_op($urandom_range(0, 7)), rand_operand(), rand_operand());
      for (int k = 0; k < 45; k++) begin
        if (r % 2 == 0 || $urandom_range(0, 3) != 0) begin
          drive_op(pick_alu_op($urandom_range(0, 9)), rand_operand(), rand_operand());
        end else begin
          idle_cycle();
        end
      end
      drain_results();
    end

    // flush halfway through a divide, any result in the window is an error
    drive_op(rv32im_pkg::op_div, rand_operand(), 32'd3);
    repeat (11) drive_op(pick_alu_op($urandom_range(0, 9)), rand_operand(), rand_operand());
    // equal operands leave equal_o set for the flush to clear
    drive_op(rv32im_pkg::op_xor, 32'h5a5a_5a5a, 32'h5a5a_5a5a);
    flush_stage();
    idle_cycles(50);
    // flush while a multiply result waits in the hold register
    drive_op(rv32im_pkg::op_mulhu, rand_operand(), rand_operand());
    repeat (5) drive_op(pick_alu_op($urandom_range(0, 9)), rand_operand(), rand_operand());
    // smaller positive operand first sets both less flags
    drive_op(rv32im_pkg::op_add, 32'd5, 32'd9);
    flush_stage();
    idle_cycles(20);
    // normal operation afterwards
    drive_op(rv32im_pkg::op_remu, 32'd100, 32'd7);
    drive_op(rv32im_pkg::op_sub, 32'd5, 32'd9);
    drain_results();
    drive_op(rv32im_pkg::op_divu, 32'hffff_fff0, 32'd16);
    drain_results();

    idle_cycles(5);
    $display("%0d results checked, %0d errors, %0d assertion failures",
             chk_cnt, err_cnt, UUT.u_checker.fail_cnt);
    if (err_cnt == 0 && UUT.u_checker.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
